// File: magma_pkg.sv
// --------------------------------------------------
// Shared definitions for the tile interconnect.
// Bus widths, address map and port counts live
// here. Modules pull them in by a wildcard import.
// --------------------------------------------------

package magma_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BE_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;
	typedef logic [BE_W-1:0] bus_be_t;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 3;	// ram0, ram1, gpio

	typedef logic [$clog2(NUM_MASTERS)-1:0] master_id_t;

	// target select sits in addr[29:28]
	// 0 ram bank 0, 1 ram bank 1, 2 gpio, 3 unmapped
	localparam int SEL_LSB = 28;
	localparam int SEL_W = 2;

	typedef logic [SEL_W-1:0] slave_sel_t;

	localparam int WORD_LSB = 2;	// byte address to word index
	localparam int OFS_W = SEL_LSB - WORD_LSB;	// word offset inside a target

	localparam int RAM_WORDS = 256;
	localparam int RAM_AW = $clog2(RAM_WORDS);	// higher offset bits wrap

	localparam int GPIO_OUT_OFS = 0;
	localparam int GPIO_IN_OFS = 1;

endpackage

// File: mem_split_if.sv
// --------------------------------------------------
// One split-transaction bus link.
// The master holds req and the request fields until
// ack; a read returns rdata with a resp pulse in
// the cycle after its ack. Writes get no response.
// --------------------------------------------------

interface mem_split_if import magma_pkg::*; ();

	logic req;
	logic we;
	bus_addr_t addr;
	bus_be_t be;
	bus_data_t wdata;
	logic ack;	// one-cycle pulse on acceptance
	logic resp;	// one-cycle pulse with read data
	bus_data_t rdata;

	modport master (
		output req
		, output we
		, output addr
		, output be
		, output wdata
		, input ack
		, input resp
		, input rdata
	);

	modport slave (
		input req
		, input we
		, input addr
		, input be
		, input wdata
		, output ack
		, output resp
		, output rdata
	);

endinterface

// File: bus_arbiter.sv
// --------------------------------------------------
// Round-robin arbiter for one crossbar target.
// Grant is combinational from the requests and the
// last-grant register. On a granted read the master
// id is kept so the crossbar can steer the response.
// --------------------------------------------------

module bus_arbiter import magma_pkg::*; (
	input logic clk_i
	, input logic rst_i
	, input logic [NUM_MASTERS-1:0] req_i
	, input logic [NUM_MASTERS-1:0] we_i
	, output logic [NUM_MASTERS-1:0] grant_o
	, output master_id_t resp_owner_o
);

	master_id_t last_q;	// master granted most recently
	master_id_t owner_q;
	master_id_t gnt_id;
	logic gnt_valid;

	// search starts just after the last winner
	always_comb begin
		int idx;
		gnt_valid = 1'b0;
		gnt_id = last_q;
		for (int k = 1; k <= NUM_MASTERS; k++) begin
			idx = (int'(last_q) + k) % NUM_MASTERS;
			if (!gnt_valid && req_i[idx]) begin
				gnt_valid = 1'b1;
				gnt_id = master_id_t'(idx);
			end
		end
	end

	always_comb begin
		grant_o = '0;
		if (gnt_valid) begin
			grant_o[gnt_id] = 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			last_q <= master_id_t'(NUM_MASTERS - 1);	// master 0 wins first
			owner_q <= '0;
		end else if (gnt_valid) begin
			last_q <= gnt_id;
			if (!we_i[gnt_id]) begin
				owner_q <= gnt_id;	// resp follows next cycle
			end
		end
	end

	assign resp_owner_o = owner_q;

endmodule

// File: ariele_xbar.sv
// --------------------------------------------------
// Crossbar between the bus masters and the targets.
// Each target has its own arbiter, so masters going
// to different targets are served in the same cycle.
// Read responses go back to the recorded owner and
// unmapped requests are answered here with zero.
// --------------------------------------------------

module ariele_xbar import magma_pkg::*; (
	input logic clk_i
	, input logic rst_i
	, mem_split_if.slave m0
	, mem_split_if.slave m1
	, mem_split_if.master s0
	, mem_split_if.master s1
	, mem_split_if.master s2
);

	logic [NUM_MASTERS-1:0] m_req, m_we, m_ack, m_resp;
	bus_addr_t m_addr [NUM_MASTERS];
	bus_be_t m_be [NUM_MASTERS];
	bus_data_t m_wdata [NUM_MASTERS];
	bus_data_t m_rdata [NUM_MASTERS];
	slave_sel_t m_sel [NUM_MASTERS];

	logic [NUM_SLAVES-1:0] s_req, s_we, s_ack, s_resp;
	bus_addr_t s_addr [NUM_SLAVES];
	bus_be_t s_be [NUM_SLAVES];
	bus_data_t s_wdata [NUM_SLAVES];
	bus_data_t s_rdata [NUM_SLAVES];

	logic [NUM_MASTERS-1:0] t_req [NUM_SLAVES];	// per-target request vectors
	logic [NUM_MASTERS-1:0] t_grant [NUM_SLAVES];
	master_id_t t_owner [NUM_SLAVES];

	logic [NUM_MASTERS-1:0] unm_req;
	logic [NUM_MASTERS-1:0] unm_resp_q;

	assign m_req = {m1.req, m0.req};
	assign m_we = {m1.we, m0.we};
	assign m_addr = '{m0.addr, m1.addr};
	assign m_be = '{m0.be, m1.be};
	assign m_wdata = '{m0.wdata, m1.wdata};

	assign s_ack = {s2.ack, s1.ack, s0.ack};
	assign s_resp = {s2.resp, s1.resp, s0.resp};
	assign s_rdata = '{s0.rdata, s1.rdata, s2.rdata};

	// address decode
	always_comb begin
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_sel[m] = m_addr[m][SEL_LSB +: SEL_W];
			unm_req[m] = m_req[m] && (int'(m_sel[m]) >= NUM_SLAVES);
			for (int t = 0; t < NUM_SLAVES; t++) begin
				t_req[t][m] = m_req[m] && (int'(m_sel[m]) == t);
			end
		end
	end

	for (genvar t = 0; t < NUM_SLAVES; t++) begin : g_arb
		bus_arbiter arb (
			.clk_i(clk_i)
			, .rst_i(rst_i)
			, .req_i(t_req[t])
			, .we_i(m_we)
			, .grant_o(t_grant[t])
			, .resp_owner_o(t_owner[t])
		);
	end

	// winner's request onto each target
	always_comb begin
		for (int t = 0; t < NUM_SLAVES; t++) begin
			s_req[t] = |t_grant[t];
			s_we[t] = 1'b0;
			s_addr[t] = '0;
			s_be[t] = '0;
			s_wdata[t] = '0;
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (t_grant[t][m]) begin
					s_we[t] = m_we[m];
					s_addr[t] = m_addr[m];
					s_be[t] = m_be[m];
					s_wdata[t] = m_wdata[m];
				end
			end
		end
	end

	// acks and responses back to the masters
	always_comb begin
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_ack[m] = unm_req[m];
			m_resp[m] = unm_resp_q[m];	// unmapped read data stays zero
			m_rdata[m] = '0;
			for (int t = 0; t < NUM_SLAVES; t++) begin
				m_ack[m] = m_ack[m] | (t_grant[t][m] & s_ack[t]);
				if (s_resp[t] && (t_owner[t] == master_id_t'(m))) begin
					m_resp[m] = 1'b1;
					m_rdata[m] = s_rdata[t];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			unm_resp_q <= '0;
		end else begin
			unm_resp_q <= unm_req & ~m_we;
		end
	end

	assign m0.ack = m_ack[0];
	assign m0.resp = m_resp[0];
	assign m0.rdata = m_rdata[0];
	assign m1.ack = m_ack[1];
	assign m1.resp = m_resp[1];
	assign m1.rdata = m_rdata[1];

	assign s0.req = s_req[0];
	assign s0.we = s_we[0];
	assign s0.addr = s_addr[0];
	assign s0.be = s_be[0];
	assign s0.wdata = s_wdata[0];
	assign s1.req = s_req[1];
	assign s1.we = s_we[1];
	assign s1.addr = s_addr[1];
	assign s1.be = s_be[1];
	assign s1.wdata = s_wdata[1];
	assign s2.req = s_req[2];
	assign s2.we = s_we[2];
	assign s2.addr = s_addr[2];
	assign s2.be = s_be[2];
	assign s2.wdata = s_wdata[2];

endmodule

// File: bus_ram.sv
// --------------------------------------------------
// RAM bank target on a split-transaction link.
// Requests are accepted at once; read data comes
// back with resp one cycle later. Writes update
// only the enabled bytes.
// --------------------------------------------------

module bus_ram import magma_pkg::*; (
	input logic clk_i
	, input logic rst_i
	, mem_split_if.slave bus
);

	bus_data_t mem [RAM_WORDS];
	bus_data_t rdata_q;
	logic resp_q;
	logic [RAM_AW-1:0] word_idx;

	assign word_idx = bus.addr[WORD_LSB +: RAM_AW];	// upper offset bits ignored
	assign bus.ack = bus.req;

	always_ff @(posedge clk_i) begin
		if (bus.req && bus.we) begin
			for (int b = 0; b < BE_W; b++) begin
				if (bus.be[b]) begin
					mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (bus.req && !bus.we) begin
			rdata_q <= mem[word_idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			resp_q <= 1'b0;
		end else begin
			resp_q <= bus.req & ~bus.we;
		end
	end

	assign bus.resp = resp_q;
	assign bus.rdata = rdata_q;

endmodule

// File: gpio.sv
// --------------------------------------------------
// GPIO target.
// Word 0 is the output register, byte-enabled and
// readable. Word 1 reads the synchronised inputs.
// Any other offset reads zero and ignores writes.
// --------------------------------------------------

module gpio import magma_pkg::*; (
	input logic clk_i
	, input logic rst_i
	, mem_split_if.slave bus
	, input bus_data_t gpio_i
	, output bus_data_t gpio_o
);

	bus_data_t out_q;
	bus_data_t sync1_q, sync2_q;	// two-flop synchroniser
	bus_data_t rdata_q;
	logic resp_q;
	logic sel_out, sel_in;

	assign sel_out = bus.addr[WORD_LSB +: OFS_W] == OFS_W'(GPIO_OUT_OFS);
	assign sel_in = bus.addr[WORD_LSB +: OFS_W] == OFS_W'(GPIO_IN_OFS);
	assign bus.ack = bus.req;

	always_ff @(posedge clk_i) begin
		sync1_q <= gpio_i;
		sync2_q <= sync1_q;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_q <= '0;
			resp_q <= 1'b0;
		end else begin
			resp_q <= bus.req & ~bus.we;
			if (bus.req && bus.we && sel_out) begin
				for (int b = 0; b < BE_W; b++) begin
					if (bus.be[b]) begin
						out_q[8*b +: 8] <= bus.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (bus.req && !bus.we) begin
			rdata_q <= sel_out ? out_q : (sel_in ? sync2_q : '0);
		end
	end

	assign bus.resp = resp_q;
	assign bus.rdata = rdata_q;
	assign gpio_o = out_q;

endmodule

// File: magma.sv
// --------------------------------------------------
// Interconnect top level.
// Two external bus masters reach two RAM banks and
// a GPIO block through the crossbar. Master ports
// are plain signals and are bundled into links here.
// --------------------------------------------------

module magma import magma_pkg::*; (
	input logic clk_i
	, input logic rst_i

	, input logic m0_req_i
	, input logic m0_we_i
	, input bus_addr_t m0_addr_i
	, input bus_be_t m0_be_i
	, input bus_data_t m0_wdata_i
	, output logic m0_ack_o
	, output logic m0_resp_o
	, output bus_data_t m0_rdata_o

	, input logic m1_req_i
	, input logic m1_we_i
	, input bus_addr_t m1_addr_i
	, input bus_be_t m1_be_i
	, input bus_data_t m1_wdata_i
	, output logic m1_ack_o
	, output logic m1_resp_o
	, output bus_data_t m1_rdata_o

	, input bus_data_t gpio_i
	, output bus_data_t gpio_o
);

	mem_split_if m0 ();
	mem_split_if m1 ();
	mem_split_if s0 ();	// ram bank 0
	mem_split_if s1 ();	// ram bank 1
	mem_split_if s2 ();	// gpio

	assign m0.req = m0_req_i;
	assign m0.we = m0_we_i;
	assign m0.addr = m0_addr_i;
	assign m0.be = m0_be_i;
	assign m0.wdata = m0_wdata_i;
	assign m0_ack_o = m0.ack;
	assign m0_resp_o = m0.resp;
	assign m0_rdata_o = m0.rdata;

	assign m1.req = m1_req_i;
	assign m1.we = m1_we_i;
	assign m1.addr = m1_addr_i;
	assign m1.be = m1_be_i;
	assign m1.wdata = m1_wdata_i;
	assign m1_ack_o = m1.ack;
	assign m1_resp_o = m1.resp;
	assign m1_rdata_o = m1.rdata;

	ariele_xbar xbar (
		.clk_i(clk_i)
		, .rst_i(rst_i)
		, .m0(m0.slave)
		, .m1(m1.slave)
		, .s0(s0.master)
		, .s1(s1.master)
		, .s2(s2.master)
	);

	bus_ram ram0 (
		.clk_i(clk_i)
		, .rst_i(rst_i)
		, .bus(s0.slave)
	);

	bus_ram ram1 (
		.clk_i(clk_i)
		, .rst_i(rst_i)
		, .bus(s1.slave)
	);

	gpio gpio (
		.clk_i(clk_i)
		, .rst_i(rst_i)
		, .bus(s2.slave)
		, .gpio_i(gpio_i)
		, .gpio_o(gpio_o)
	);

endmodule

// File: magma_tb.sv
// --------------------------------------------------
// Self-checking testbench for the interconnect top.
// Both masters run GPIO contention, a parallel RAM
// fill, random traffic and a read burst. Expected
// read data and gpio_o come from a reference model.
// --------------------------------------------------

module magma_tb import magma_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int CONT_N = 8;	// gpio writes per master under contention
	localparam int RAND_N = 200;
	localparam int BURST_N = 16;
	localparam int TXN_COUNT = 2 * CONT_N + 2 * RAM_WORDS + 2 * RAND_N + BURST_N;
	localparam int WATCHDOG_NS = (TXN_COUNT * 8 + 16) * CLK_PERIOD;
	localparam int CONTEND = 0;
	localparam int FILL = 1;
	localparam int RANDOM = 2;
	localparam int BURST = 3;

	logic clk_i, rst_i;
	logic [NUM_MASTERS-1:0] req, we;
	wire [NUM_MASTERS-1:0] ack, resp;
	bus_addr_t addr [NUM_MASTERS];
	bus_be_t be [NUM_MASTERS];
	bus_data_t wdata [NUM_MASTERS];
	bus_data_t rdata [NUM_MASTERS];
	bus_data_t gpio_i, gpio_o;

	bus_data_t ram_ref [2][RAM_WORDS];
	bus_data_t gpio_out_ref, gpio_in_ref;
	bus_data_t exp_q [NUM_MASTERS][$];	// expected read data in issue order
	int ack_cyc_q [NUM_MASTERS][$];
	int gpio_order [$];	// masters acked at gpio while contending
	logic record_gpio;
	int cycle;
	logic [31:0] lfsr_q = 32'h7d4f_7616;

	magma DUT (
		.clk_i(clk_i)
		, .rst_i(rst_i)
		, .m0_req_i(req[0])
		, .m0_we_i(we[0])
		, .m0_addr_i(addr[0])
		, .m0_be_i(be[0])
		, .m0_wdata_i(wdata[0])
		, .m0_ack_o(ack[0])
		, .m0_resp_o(resp[0])
		, .m0_rdata_o(rdata[0])
		, .m1_req_i(req[1])
		, .m1_we_i(we[1])
		, .m1_addr_i(addr[1])
		, .m1_be_i(be[1])
		, .m1_wdata_i(wdata[1])
		, .m1_ack_o(ack[1])
		, .m1_resp_o(resp[1])
		, .m1_rdata_o(rdata[1])
		, .gpio_i(gpio_i)
		, .gpio_o(gpio_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic bus_data_t merge_bytes(input bus_data_t old, input bus_data_t d,
			input bus_be_t b);
		bus_data_t r;
		r = old;
		for (int i = 0; i < BE_W; i++) begin
			if (b[i]) begin
				r[8*i +: 8] = d[8*i +: 8];
			end
		end
		return r;
	endfunction

	function automatic bus_data_t expect_read(input bus_addr_t a);
		slave_sel_t sel;
		int ofs;
		sel = a[SEL_LSB +: SEL_W];
		ofs = int'(a[SEL_LSB-1:WORD_LSB]);
		if (sel < 2'd2) return ram_ref[sel[0]][a[WORD_LSB +: RAM_AW]];
		if (sel == 2'd2 && ofs == GPIO_OUT_OFS) return gpio_out_ref;
		if (sel == 2'd2 && ofs == GPIO_IN_OFS) return gpio_in_ref;
		return '0;	// unmapped, or an unused gpio word
	endfunction

	function automatic void apply_write(input bus_addr_t a, input bus_be_t b, input bus_data_t d);
		slave_sel_t sel;
		logic [RAM_AW-1:0] w;
		sel = a[SEL_LSB +: SEL_W];
		w = a[WORD_LSB +: RAM_AW];
		if (sel < 2'd2) begin
			ram_ref[sel[0]][w] = merge_bytes(ram_ref[sel[0]][w], d, b);
		end else if (sel == 2'd2 && int'(a[SEL_LSB-1:WORD_LSB]) == GPIO_OUT_OFS) begin
			gpio_out_ref = merge_bytes(gpio_out_ref, d, b);
		end
	endfunction

	function automatic bus_addr_t make_addr(input slave_sel_t sel, input logic [9:0] ofs);
		bus_addr_t a;
		a = '0;
		a[SEL_LSB +: SEL_W] = sel;
		a[WORD_LSB +: 10] = ofs;	// bits above the ram index exercise the wrap
		return a;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_rdata(input string name, input bus_data_t exp, input bus_data_t act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act));
		end
	endtask

	task automatic check_gpio(input bus_data_t exp, input bus_data_t act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch at %0d ns: gpio_o expected %h, got %h", $time, exp, act));
		end
	endtask

	// present one request and hold it until acked
	task automatic issue(input int m, input logic w, input bus_addr_t a, input bus_be_t b,
			input bus_data_t d);
		int waited;
		waited = 0;
		req[m] = 1'b1;
		we[m] = w;
		addr[m] = a;
		be[m] = b;
		wdata[m] = d;
		@(negedge clk_i);
		while (!ack[m]) begin
			waited++;
			if (waited >= NUM_MASTERS) begin
				fail_run($sformatf("request of master %0d was not acknowledged in time", m));
			end
			@(negedge clk_i);
		end
		@(posedge clk_i);
		#1;
	endtask

	task automatic idle_for(input int m, input int n);
		req[m] = 1'b0;
		if (n > 0) begin
			repeat (n) @(posedge clk_i);
			#1;
		end
	endtask

	task automatic traffic(input int m, input int kind, input int n);
		slave_sel_t sel;
		logic [9:0] ofs;
		logic w;
		bus_be_t b;
		for (int i = 0; i < n; i++) begin
			sel = slave_sel_t'(rand_bits(2));
			ofs = 10'(rand_bits(10));
			w = 1'(rand_bits(1));
			b = bus_be_t'(rand_bits(4));
			case (kind)
				CONTEND: begin
					sel = 2'd2;
					ofs = 10'(GPIO_OUT_OFS);
					w = 1'b1;
				end
				FILL: begin
					sel = slave_sel_t'(m);
					ofs = 10'(i);
					w = 1'b1;
					b = '1;
				end
				BURST: begin
					sel = 2'd1;
					w = 1'b0;
				end
				default: begin
					if (sel == 2'd2) ofs = {8'd0, ofs[1:0]};	// out, in and two unused words
				end
			endcase
			issue(m, w, make_addr(sel, ofs), b, rand_bits(32));
			idle_for(m, (kind == RANDOM) ? int'(rand_bits(2)) : 0);
		end
	endtask

	// reference model and response compare
	always @(negedge clk_i) begin
		if (!rst_i) begin
			cycle++;
			check_gpio(gpio_out_ref, gpio_o);
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (resp[m]) begin
					if (exp_q[m].size() == 0) begin
						fail_run($sformatf("master %0d got a response with no read outstanding", m));
					end
					if (ack_cyc_q[m].pop_front() != cycle - 1) begin
						fail_run($sformatf("master %0d response not one cycle after its ack", m));
					end
					check_rdata($sformatf("m%0d_rdata_o", m), exp_q[m].pop_front(), rdata[m]);
				end
			end
			if (req == 2'b11 && addr[0][SEL_LSB +: SEL_W] != addr[1][SEL_LSB +: SEL_W]
					&& ack != 2'b11) begin
				fail_run("requests to different targets were not both acknowledged");
			end
			if (ack == 2'b11 && addr[0][SEL_LSB +: SEL_W] == addr[1][SEL_LSB +: SEL_W]
					&& addr[0][SEL_LSB +: SEL_W] != 2'd3) begin
				fail_run("one target acknowledged both masters in the same cycle");
			end
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (ack[m] && !req[m]) begin
					fail_run($sformatf("master %0d acknowledged without a request", m));
				end
				if (ack[m] && we[m]) begin
					apply_write(addr[m], be[m], wdata[m]);
				end else if (ack[m]) begin
					exp_q[m].push_back(expect_read(addr[m]));
					ack_cyc_q[m].push_back(cycle);
				end
				if (ack[m] && record_gpio && addr[m][SEL_LSB +: SEL_W] == 2'd2) begin
					gpio_order.push_back(m);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout: the run did not finish in the expected time");
	end

	initial begin
		clk_i = 1'b0;
		rst_i = 1'b1;
		req = '0;
		we = '0;
		gpio_i = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			addr[m] = '0;
			be[m] = '0;
			wdata[m] = '0;
		end
		gpio_out_ref = '0;
		gpio_in_ref = '0;
		record_gpio = 1'b0;
		cycle = 0;
		repeat (16) @(posedge clk_i);
		#1 rst_i = 1'b0;
		@(negedge clk_i);
		if (ack !== '0 || resp !== '0) begin
			fail_run("ack or resp active right after reset");
		end
		@(posedge clk_i);
		#1;
		record_gpio = 1'b1;	// both masters hit gpio every cycle
		fork
			traffic(0, CONTEND, CONT_N);
			traffic(1, CONTEND, CONT_N);
		join
		record_gpio = 1'b0;
		for (int i = 0; i < gpio_order.size(); i++) begin
			if (gpio_order[i] != i % 2) begin
				fail_run("acks under contention did not alternate starting with master 0");
			end
		end
		fork
			traffic(0, FILL, RAM_WORDS);
			traffic(1, FILL, RAM_WORDS);
		join
		gpio_i = rand_bits(32);
		gpio_in_ref = gpio_i;
		repeat (3) @(posedge clk_i);	// let the synchroniser settle
		#1;
		fork
			traffic(0, RANDOM, RAND_N);
			traffic(1, RANDOM, RAND_N);
		join
		traffic(0, BURST, BURST_N);
		repeat (3) @(posedge clk_i);
		if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
			fail_run("a read was acknowledged but never got its response");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// File: flist.f
magma_pkg.sv
mem_split_if.sv
bus_arbiter.sv
ariele_xbar.sv
bus_ram.sv
gpio.sv
magma.sv
magma_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log for the pass line
verilator --binary --timing -Wno-fatal --top-module magma_tb -f flist.f -o magma_sim \
	&& ./obj_dir/magma_sim | tee sim.log \
	&& grep -q "^Regression passed$" sim.log \
	|| { echo "simulation did not pass, see sim.log"; exit 1; }
